// ==== bench/tb_clock_gen.sv ====
// Testbench clock source
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk
);

    // 100 ns period
    localparam time HALF_PERIOD = 50ns;

    initial begin
        clk = 1'b0;
    end

    always #(HALF_PERIOD) clk = ~clk;

endmodule

`default_nettype wire

// ==== bench/tb_cluster_dcr_fabric.sv ====
// Configuration write distributor testbench
`timescale 1ns/1ps
`default_nettype none

module tb_cluster_dcr_fabric;

    import dcr_pkg::*;

    localparam int TOTAL_WORDS = NUM_REGIONS * REGION_WORDS;

    logic        clk;
    logic        rst_n;
    logic        write_valid;
    dcr_addr_t   write_addr;
    dcr_data_t   write_data;
    logic        rd_en;
    dcr_region_t rd_region;
    dcr_index_t  rd_index;
    logic        rd_valid;
    dcr_data_t   rd_data;
    logic        busy;

    int          errors = 0;
    dcr_data_t   state_model [TOTAL_WORDS];
    dcr_data_t   exp_q [$];

    tb_clock_gen i_clock_gen (.clk(clk));

    cluster_dcr_fabric i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .write_valid (write_valid),
        .write_addr  (write_addr),
        .write_data  (write_data),
        .rd_en       (rd_en),
        .rd_region   (rd_region),
        .rd_index    (rd_index),
        .rd_valid    (rd_valid),
        .rd_data     (rd_data),
        .busy        (busy)
    );

    //************************************************************
    // Reference model
    //************************************************************

    function automatic dcr_addr_t region_begin(input int r);
        case (r)
            0:       return 12'h100;
            1:       return 12'h200;
            2:       return 12'h300;
            default: return 12'h400;
        endcase
    endfunction

    // Flags an in-range address and gives its slot and current word
    function automatic logic expected_region_word(input dcr_addr_t addr, output int slot,
                                                  output dcr_data_t word);
        dcr_addr_t lo;
        logic      found;
        found = 1'b0;
        slot  = 0;
        for (int r = 0; r < NUM_REGIONS; r++) begin
            lo = region_begin(r);
            if (addr >= lo && addr < lo + dcr_addr_t'(REGION_WORDS)) begin
                found = 1'b1;
                slot  = r * int'(REGION_WORDS) + int'(addr - lo);
            end
        end
        word = state_model[slot];
        return found;
    endfunction

    //************************************************************
    // Stimulus tasks
    //************************************************************

    task automatic write_cfg(input dcr_addr_t addr, input dcr_data_t data);
        int        slot;
        dcr_data_t old_word;
        @(posedge clk);
        #10;
        write_valid = 1'b1;
        write_addr  = addr;
        write_data  = data;
        rd_en       = 1'b0;
        if (expected_region_word(addr, slot, old_word)) begin
            state_model[slot] = data;
        end
    endtask

    task automatic read_word(input int r, input int i);
        int        slot;
        dcr_data_t word;
        @(posedge clk);
        #10;
        write_valid = 1'b0;
        rd_en       = 1'b1;
        rd_region   = dcr_region_t'(r);
        rd_index    = dcr_index_t'(i);
        void'(expected_region_word(region_begin(r) + dcr_addr_t'(i), slot, word));
        exp_q.push_back(word);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #10;
            write_valid = 1'b0;
            rd_en       = 1'b0;
        end
    endtask

    task automatic wait_reads_done();
        int guard;
        guard = 0;
        while (exp_q.size() != 0 && guard < 20) begin
            @(posedge clk);
            guard++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("readback did not finish in time, %0d reads outstanding", exp_q.size());
            exp_q.delete();
        end
    endtask

    task automatic wait_idle();
        int guard;
        guard = 0;
        while (busy !== 1'b0 && guard < 10) begin
            @(negedge clk);
            guard++;
        end
        if (busy !== 1'b0) begin
            errors++;
            $display("busy stayed high after the last write");
        end
    endtask

    task automatic read_all();
        for (int r = 0; r < NUM_REGIONS; r++) begin
            for (int i = 0; i < REGION_WORDS; i++) begin
                read_word(r, i);
            end
        end
        idle_cycles(1);
        wait_reads_done();
    endtask

    //************************************************************
    // Output monitor
    //************************************************************

    initial begin : monitor
        int        guard;
        int        slot;
        logic      exp_valid;
        logic      exp_busy;
        dcr_data_t word;
        dcr_data_t want;
        guard = 0;
        while (rst_n !== 1'b1 && guard < 50) begin
            @(negedge clk);
            guard++;
        end
        if (rst_n !== 1'b1) begin
            errors++;
            $display("reset was never released");
        end
        exp_valid = rd_en;
        exp_busy  = write_valid && expected_region_word(write_addr, slot, word);
        forever begin
            @(negedge clk);
            if (busy !== exp_busy) begin
                errors++;
                $display("mismatch busy: got %h expected %h", busy, exp_busy);
            end
            if (rd_valid !== exp_valid) begin
                errors++;
                $display("mismatch rd_valid: got %h expected %h", rd_valid, exp_valid);
            end
            if (rd_valid === 1'b1) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("read data returned with no read outstanding");
                end else begin
                    want = exp_q.pop_front();
                    if (rd_data !== want) begin
                        errors++;
                        $display("mismatch rd_data: got %h expected %h", rd_data, want);
                    end
                end
            end
            // Inputs now stable are the ones the next edge samples
            exp_valid = rd_en;
            exp_busy  = write_valid && expected_region_word(write_addr, slot, word);
        end
    end

    //************************************************************
    // Test sequence
    //************************************************************

    initial begin : main
        int unsigned seed_value;
        dcr_addr_t   addr;
        int          r;
        int          i;
        seed_value  = $urandom(32'hb436);
        rst_n       = 1'b0;
        write_valid = 1'b0;
        write_addr  = '0;
        write_data  = '0;
        rd_en       = 1'b0;
        rd_region   = region_base;
        rd_index    = '0;
        for (int k = 0; k < TOTAL_WORDS; k++) begin
            state_model[k] = '0;
        end
        repeat (5) @(posedge clk);
        #10;
        rst_n = 1'b1;

        // Clean state after reset
        @(negedge clk);
        if (busy !== 1'b0) begin
            errors++;
            $display("mismatch busy: got %h expected %h", busy, 1'b0);
        end
        if (rd_valid !== 1'b0) begin
            errors++;
            $display("mismatch rd_valid: got %h expected %h", rd_valid, 1'b0);
        end
        read_all();

        // Every word of every region
        for (int rr = 0; rr < NUM_REGIONS; rr++) begin
            for (int ii = 0; ii < REGION_WORDS; ii++) begin
                write_cfg(region_begin(rr) + dcr_addr_t'(ii), dcr_data_t'($urandom()));
            end
        end
        idle_cycles(2);
        wait_idle();
        read_all();

        // Edges of each range and the gaps between them
        for (int rr = 0; rr < NUM_REGIONS; rr++) begin
            write_cfg(region_begin(rr) - 12'h001, dcr_data_t'($urandom()));
            write_cfg(region_begin(rr) + dcr_addr_t'(REGION_WORDS), dcr_data_t'($urandom()));
            write_cfg(region_begin(rr) + 12'h080, dcr_data_t'($urandom()));
        end
        for (int k = 0; k < 8; k++) begin
            addr = dcr_addr_t'(32'h500 + ($urandom() % 32'hb00));
            write_cfg(addr, dcr_data_t'($urandom()));
        end
        idle_cycles(2);
        read_all();

        // Back-to-back mix of hits and misses
        for (int k = 0; k < 64; k++) begin
            if ($urandom() % 2 == 0) begin
                r    = int'($urandom() % NUM_REGIONS);
                i    = int'($urandom() % REGION_WORDS);
                addr = region_begin(r) + dcr_addr_t'(i);
            end else begin
                addr = dcr_addr_t'($urandom());
            end
            write_cfg(addr, dcr_data_t'($urandom()));
        end
        idle_cycles(2);
        wait_idle();
        read_all();

        // Read two edges after a write sees the new word
        for (int k = 0; k < 8; k++) begin
            r = int'($urandom() % NUM_REGIONS);
            i = int'($urandom() % REGION_WORDS);
            write_cfg(region_begin(r) + dcr_addr_t'(i), dcr_data_t'($urandom()));
            idle_cycles(1);
            read_word(r, i);
            idle_cycles(k % 3);
        end
        idle_cycles(1);
        wait_reads_done();
        wait_idle();

        $display("checks done, errors: %0d", errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== common/dcr_pkg.sv ====
// Configuration write definitions
`default_nettype none

package dcr_pkg;

    //**********************************************************
    // Sizes
    //**********************************************************

    localparam int unsigned NUM_REGIONS  = 4;
    localparam int unsigned REGION_WORDS = 8;

    //**********************************************************
    // Types
    //**********************************************************

    // Raw write address and data as seen on the configuration bus
    typedef logic [11:0] dcr_addr_t;
    typedef logic [31:0] dcr_data_t;

    // Target state block of a decoded write
    typedef enum logic [1:0] {
        region_base   = 2'd0,
        region_tex    = 2'd1,
        region_raster = 2'd2,
        region_rop    = 2'd3
    } dcr_region_t;

    // Word offset inside one region
    typedef logic [2:0] dcr_index_t;

    //**********************************************************
    // Address map
    //**********************************************************

    // Each region spans [begin, begin + REGION_WORDS)
    localparam dcr_addr_t BASE_STATE_BEGIN   = 12'h100;
    localparam dcr_addr_t TEX_STATE_BEGIN    = 12'h200;
    localparam dcr_addr_t RASTER_STATE_BEGIN = 12'h300;
    localparam dcr_addr_t ROP_STATE_BEGIN    = 12'h400;

endpackage

`default_nettype wire

// ==== common/dcr_wr_if.sv ====
// Decoded configuration write
`timescale 1ns/1ps
`default_nettype none

interface dcr_wr_if;

    import dcr_pkg::*;

    // One-cycle strobe, fields below only hold meaning while it is high
    logic        wr_valid;
    dcr_region_t wr_region;
    dcr_index_t  wr_index;
    dcr_data_t   wr_data;

    // Decode stage side
    modport source (
        output wr_valid,
        output wr_region,
        output wr_index,
        output wr_data
    );

    // State bank side
    modport sink (
        input wr_valid,
        input wr_region,
        input wr_index,
        input wr_data
    );

endinterface

`default_nettype wire

// ==== dcr/dcr_range_decode.sv ====
// Configuration write range decoder
`timescale 1ns/1ps
`default_nettype none

module dcr_range_decode (
    input  logic               clk,
    input  logic               rst_n,

    input  logic               write_valid,
    input  dcr_pkg::dcr_addr_t write_addr,
    input  dcr_pkg::dcr_data_t write_data,

    dcr_wr_if.source           wr,

    output logic               busy
);

    import dcr_pkg::*;

    // True when addr falls inside the region starting at lo
    function automatic logic in_range(input dcr_addr_t addr, input dcr_addr_t lo);
        dcr_addr_t hi;
        hi = lo + dcr_addr_t'(REGION_WORDS);
        return (addr >= lo) && (addr < hi);
    endfunction

    logic [NUM_REGIONS-1:0] hit;
    dcr_region_t            region;
    dcr_addr_t              offset;

    logic                   valid_q;
    dcr_region_t            region_q;
    dcr_index_t             index_q;
    dcr_data_t              data_q;

    //**********************************************************
    // Address match
    //**********************************************************

    // Every range is checked on its own so overlaps stay visible
    always_comb begin
        hit    = '0;
        region = region_base;
        offset = '0;
        if (in_range(write_addr, BASE_STATE_BEGIN)) begin
            hit[region_base] = 1'b1;
            region           = region_base;
            offset           = write_addr - BASE_STATE_BEGIN;
        end
        if (in_range(write_addr, TEX_STATE_BEGIN)) begin
            hit[region_tex] = 1'b1;
            region          = region_tex;
            offset          = write_addr - TEX_STATE_BEGIN;
        end
        if (in_range(write_addr, RASTER_STATE_BEGIN)) begin
            hit[region_raster] = 1'b1;
            region             = region_raster;
            offset             = write_addr - RASTER_STATE_BEGIN;
        end
        if (in_range(write_addr, ROP_STATE_BEGIN)) begin
            hit[region_rop] = 1'b1;
            region          = region_rop;
            offset          = write_addr - ROP_STATE_BEGIN;
        end
    end

    //**********************************************************
    // Write buffer
    //**********************************************************

    // Unmatched writes are dropped here
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= write_valid && (|hit);
        end
    end

    always_ff @(posedge clk) begin
        if (write_valid) begin
            region_q <= region;
            index_q  <= dcr_index_t'(offset);
            data_q   <= write_data;
        end
    end

    assign wr.wr_valid  = valid_q;
    assign wr.wr_region = region_q;
    assign wr.wr_index  = index_q;
    assign wr.wr_data   = data_q;

    // Only the buffered write can still be outstanding
    assign busy = valid_q;

    // Address map must not overlap
    a_single_region : assert property (
        @(posedge clk) disable iff (!rst_n)
        write_valid |-> $onehot0(hit)
    );

endmodule

`default_nettype wire

// ==== dcr/dcr_state_bank.sv ====
// Configuration state bank
`timescale 1ns/1ps
`default_nettype none

module dcr_state_bank (
    input  logic                 clk,
    input  logic                 rst_n,

    dcr_wr_if.sink               wr,

    input  logic                 rd_en,
    input  dcr_pkg::dcr_region_t rd_region,
    input  dcr_pkg::dcr_index_t  rd_index,
    output logic                 rd_valid,
    output dcr_pkg::dcr_data_t   rd_data
);

    import dcr_pkg::*;

    // One row per region
    dcr_data_t state_q [NUM_REGIONS][REGION_WORDS];

    logic      rd_valid_q;
    dcr_data_t rd_data_q;

    //**********************************************************
    // State update
    //**********************************************************

    // Units expect a known zero state until software programs them
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < NUM_REGIONS; r++) begin
                for (int w = 0; w < REGION_WORDS; w++) begin
                    state_q[r][w] <= '0;
                end
            end
        end else if (wr.wr_valid) begin
            state_q[wr.wr_region][wr.wr_index] <= wr.wr_data;
        end
    end

    //**********************************************************
    // Readback
    //**********************************************************

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= rd_en;
        end
    end

    // A write on the same edge is not seen yet
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data_q <= state_q[rd_region][rd_index];
        end
    end

    assign rd_valid = rd_valid_q;
    assign rd_data  = rd_data_q;

    // Decode stage must hand over a clean target with every strobe
    a_known_target : assert property (
        @(posedge clk) disable iff (!rst_n)
        wr.wr_valid |-> !$isunknown({wr.wr_region, wr.wr_index})
    );

endmodule

`default_nettype wire

// ==== hdl/cluster_dcr_fabric.sv ====
// Cluster configuration write distributor
`timescale 1ns/1ps
`default_nettype none

module cluster_dcr_fabric (
    input  logic                 clk,
    input  logic                 rst_n,

    // Raw configuration write
    input  logic                 write_valid,
    input  dcr_pkg::dcr_addr_t   write_addr,
    input  dcr_pkg::dcr_data_t   write_data,

    // State readback
    input  logic                 rd_en,
    input  dcr_pkg::dcr_region_t rd_region,
    input  dcr_pkg::dcr_index_t  rd_index,
    output logic                 rd_valid,
    output dcr_pkg::dcr_data_t   rd_data,

    // High while a decoded write is in flight
    output logic                 busy
);

    //**********************************************************
    // Decoded write between the two stages
    //**********************************************************

    dcr_wr_if wr_bus ();

    //**********************************************************
    // Range decode and write buffer
    //**********************************************************

    dcr_range_decode i_range_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .write_valid (write_valid),
        .write_addr  (write_addr),
        .write_data  (write_data),
        .wr          (wr_bus.source),
        .busy        (busy)
    );

    //**********************************************************
    // Per-region state storage
    //**********************************************************

    // Stands in for the state copies held by the base, texture,
    // raster and raster-op units
    dcr_state_bank i_state_bank (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr        (wr_bus.sink),
        .rd_en     (rd_en),
        .rd_region (rd_region),
        .rd_index  (rd_index),
        .rd_valid  (rd_valid),
        .rd_data   (rd_data)
    );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_cluster_dcr_fabric

rm -rf obj_dir "$LOG"

verilator --binary --timing --assert \
    --top-module "$TOP" \
    -f sources.f \
    -o "$TOP" \
    && ./obj_dir/"$TOP" > "$LOG" 2>&1 \
    || { echo "build or simulation error"; cat "$LOG" 2>/dev/null; exit 1; }

cat "$LOG"

grep -q "TEST FAILED" "$LOG" && { echo "simulation reported failure"; exit 1; }
grep -q "TEST PASSED" "$LOG" || { echo "no result found in $LOG"; exit 1; }
exit 0

// ==== sources.f ====
common/dcr_pkg.sv
common/dcr_wr_if.sv
dcr/dcr_range_decode.sv
dcr/dcr_state_bank.sv
hdl/cluster_dcr_fabric.sv
bench/tb_clock_gen.sv
bench/tb_cluster_dcr_fabric.sv
